//--- vlog.f
+incdir+source
+incdir+tb
source/ctm_pkg.sv
source/ctm_event_detect.sv
source/ctm_event_fifo.sv
source/ctm_reg_access.sv
source/ctm_packet_mux.sv
source/ctm_mmsp430.sv
tb/tb_ctm_mmsp430.sv

//--- Makefile
SIM = obj_dir/Vtb_ctm_mmsp430

$(SIM): vlog.f $(wildcard source/*.sv source/*.svh tb/*.sv tb/*.svh)
	verilator --binary --timing --assert -Wno-fatal -f vlog.f \
	  --top-module tb_ctm_mmsp430 -o Vtb_ctm_mmsp430

run: $(SIM)
	@out="$$(./$(SIM))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF "TEST RESULT: PASS"

clean:
	rm -rf obj_dir

.PHONY: run clean

//--- tb/ctm_tb_tasks.svh
// Request, trace stimulus and packet collection tasks plus the LFSR step
`ifndef CTM_TB_TASKS_SVH
`define CTM_TB_TASKS_SVH

// Fibonacci LFSR, taps 32 22 2 1
function automatic logic [31:0] lfsr_step(input logic [31:0] s);
  return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
endfunction

// Drives tx_pkt on the debug input, one flit per accepted cycle
task automatic send_packet();
  int t;
  for (int i = 0; i < tx_pkt.size(); i++) begin
    @(posedge clk);
    #2;
    debug_in_data  = tx_pkt[i];
    debug_in_last  = (i == tx_pkt.size() - 1);
    debug_in_valid = 1'b1;
    t = 0;
    @(negedge clk);
    while (!debug_in_ready) begin   // Taken at the next edge once ready
      @(negedge clk);
      t++;
      if (t > 200)
        wait_fail("debug input ready");
    end
  end
  @(posedge clk);
  #2;
  debug_in_valid = 1'b0;
  debug_in_last  = 1'b0;
endtask

task automatic read_reg(input ctm_pkg::flit_t addr);
  tx_pkt = '{DUT_ID, HOST, {`CTM_TYPE_REG, `CTM_SUB_REQ_READ, 10'b0}, addr};
  send_packet();
endtask

task automatic write_reg(input ctm_pkg::flit_t addr, input ctm_pkg::flit_t data);
  tx_pkt = '{DUT_ID, HOST, {`CTM_TYPE_REG, `CTM_SUB_REQ_WRITE, 10'b0}, addr, data};
  send_packet();
endtask

// One trace cycle, recorded when it should become an event
task automatic issue_instr(input logic jal, input logic jr,
                           input ctm_pkg::addr_t pc, input ctm_pkg::addr_t npc);
  @(posedge clk);
  #2;
  trace_valid    = 1'b1;
  trace_jal      = jal;
  trace_jr       = jr;
  trace_pc       = pc;
  trace_jbtarget = npc;
  if (trace_on && (jal || jr)) begin
    exp_pc.push_back(pc);
    exp_npc.push_back(npc);
    exp_kind.push_back({jr, jal});
    exp_ts.push_back(cyc);          // Cycle count at the accepting edge
  end
endtask

task automatic trace_idle();
  @(posedge clk);
  #2;
  trace_valid = 1'b0;
  trace_jal   = 1'b0;
  trace_jr    = 1'b0;
endtask

// Next complete packet from the monitor into pkt
task automatic get_packet(input string what);
  int t;
  int n;
  t = 0;
  while (rx_lens.size() == 0) begin
    @(posedge clk);
    t++;
    if (t > 600)
      wait_fail(what);
  end
  n = rx_lens.pop_front();
  pkt.delete();
  repeat (n) pkt.push_back(rx_flits.pop_front());
endtask

`endif

//--- tb/tb_ctm_mmsp430.sv
// Testbench for the core trace module with scenario sequence and checks
`timescale 1ns/100ps
`include "ctm_defs.svh"

module tb_ctm_mmsp430;

  localparam logic [15:0] DUT_ID = 16'h0010;
  localparam logic [15:0] HOST   = 16'h0041;   // Requester address
  localparam logic [15:0] DEST   = 16'h0022;   // Trace sink address
  localparam logic [15:0] EV_HDR = {`CTM_TYPE_EVENT, 14'b0};

  logic               clk = 1'b0;
  logic               reset;
  ctm_pkg::mod_id_t   id;
  logic               trace_valid;
  ctm_pkg::addr_t     trace_pc;
  ctm_pkg::addr_t     trace_jbtarget;
  logic               trace_jal;
  logic               trace_jr;
  ctm_pkg::flit_t     debug_in_data;
  logic               debug_in_last;
  logic               debug_in_valid;
  logic               debug_in_ready;
  ctm_pkg::flit_t     debug_out_data;
  logic               debug_out_last;
  logic               debug_out_valid;
  logic               debug_out_ready = 1'b1;

  ctm_pkg::flit_t     rx_flits[$];     // Flits taken at the output
  int                 rx_lens[$];      // Lengths of completed packets
  ctm_pkg::flit_t     pkt[$];
  ctm_pkg::flit_t     tx_pkt[$];
  ctm_pkg::addr_t     exp_pc[$];       // Events expected, in issue order
  ctm_pkg::addr_t     exp_npc[$];
  logic [1:0]         exp_kind[$];     // {ret, call}
  ctm_pkg::tstamp_t   exp_ts[$];
  int                 next_ev = 0;
  int                 delivered = 0;
  int                 drops_total = 0;
  int                 cur_len = 0;
  int                 ready_mode = 0;  // 0 high, 1 random, 2 low
  ctm_pkg::tstamp_t   last_ts = '0;
  ctm_pkg::tstamp_t   cyc;             // Cycles since reset release
  logic [31:0]        lfsr = 32'h228b;
  logic               trace_on = 1'b0;
  logic               hold_pending = 1'b0;
  ctm_pkg::flit_t     hold_data;
  logic               hold_last;

  ctm_mmsp430 #(.MAX_PKT_LEN(8)) DUT (.*);

  always #10 clk = ~clk;

  always @(posedge clk)
    cyc <= reset ? '0 : cyc + 1'b1;

  // Output back-pressure
  always @(posedge clk) begin
    #2;
    if (ready_mode == 1) begin
      lfsr = lfsr_step(lfsr);
      debug_out_ready = lfsr[0];
    end else begin
      debug_out_ready = (ready_mode == 0);
    end
  end

  task automatic value_fail(input string name, input logic [31:0] exp, input logic [31:0] act);
    $display("FAIL %s: expected %0h, actual %0h", name, exp, act);
    $display("TEST RESULT: FAIL");
    $fatal(1, "check %s failed", name);
  endtask

  task automatic wait_fail(input string what);
    $display("Timed out waiting for %s", what);
    $display("TEST RESULT: FAIL");
    $fatal(1, "timeout");
  endtask

  task automatic check_eq(input string name, input logic [31:0] exp, input logic [31:0] act);
    assert (act === exp) else value_fail(name, exp, act);
  endtask

  // Mid-cycle monitor, sees settled valid/ready
  always @(negedge clk) begin
    if (!reset) begin
      if (hold_pending) begin
        check_eq("held valid", 1, debug_out_valid);
        check_eq("held data", hold_data, debug_out_data);
        check_eq("held last", hold_last, debug_out_last);
      end
      hold_pending = debug_out_valid && !debug_out_ready;
      hold_data    = debug_out_data;
      hold_last    = debug_out_last;
      if (debug_out_valid && debug_out_ready) begin
        rx_flits.push_back(debug_out_data);
        cur_len++;
        if (debug_out_last) begin
          rx_lens.push_back(cur_len);
          cur_len = 0;
        end
      end
    end
  end

  `include "ctm_tb_tasks.svh"

  // Trace packet in pkt against the next expected event
  task automatic check_event();
    ctm_pkg::tstamp_t ts;
    ctm_pkg::flit_t   flags;
    check_eq("event length", `CTM_EVENT_FLITS, pkt.size());
    check_eq("event dest", DEST, pkt[0]);
    check_eq("event src", DUT_ID, pkt[1]);
    check_eq("event header", EV_HDR, pkt[2]);
    ts    = {pkt[4], pkt[3]};
    flags = pkt[9];
    next_ev     += flags[15:8];          // Skip the events reported lost
    drops_total += flags[15:8];
    check_eq("event within issued", 1, next_ev < exp_pc.size());
    check_eq("event tstamp", exp_ts[next_ev], ts);
    check_eq("event pc", exp_pc[next_ev], {pkt[6], pkt[5]});
    check_eq("event npc", exp_npc[next_ev], {pkt[8], pkt[7]});
    check_eq("event flags", {6'b0, exp_kind[next_ev]}, flags[7:0]);
    if (delivered > 0)
      check_eq("tstamp increase", 1, ts > last_ts);
    last_ts = ts;
    next_ev++;
    delivered++;
  endtask

  // Trace packets ahead of the response are checked on the way
  task automatic expect_resp(input string name, input logic [3:0] sub,
                             input logic has_data, input ctm_pkg::flit_t data);
    get_packet("response packet");
    while (pkt.size() == `CTM_EVENT_FLITS && pkt[2] == EV_HDR) begin
      check_event();
      get_packet("response packet");
    end
    check_eq({name, " length"}, has_data ? 4 : 3, pkt.size());
    check_eq({name, " dest"}, HOST, pkt[0]);
    check_eq({name, " src"}, DUT_ID, pkt[1]);
    check_eq({name, " header"}, {`CTM_TYPE_REG, sub, 10'b0}, pkt[2]);
    if (has_data)
      check_eq({name, " data"}, data, pkt[3]);
  endtask

  task automatic expect_quiet(input int n);
    repeat (n) @(posedge clk);
    check_eq("unexpected packet", 0, rx_lens.size());
    check_eq("unexpected flits", 0, cur_len);
  endtask

  task automatic drain_events();
    while (next_ev < exp_pc.size()) begin
      get_packet("event packet");
      check_event();
    end
  endtask

  task automatic wait_out_idle();
    int quiet;
    int t;
    quiet = 0;
    t = 0;
    while (quiet < 20) begin    // Gaps between packets are far shorter
      @(negedge clk);
      quiet = debug_out_valid ? 0 : quiet + 1;
      t++;
      if (t > 1000)
        wait_fail("output to go idle");
    end
  endtask

  initial begin
    reset          = 1'b1;
    id             = DUT_ID;
    trace_valid    = 1'b0;
    trace_pc       = '0;
    trace_jbtarget = '0;
    trace_jal      = 1'b0;
    trace_jr       = 1'b0;
    debug_in_data  = '0;
    debug_in_last  = 1'b0;
    debug_in_valid = 1'b0;
    repeat (8) @(posedge clk);
    #2;
    reset = 1'b0;
    @(negedge clk);
    check_eq("ready after reset", 1, debug_in_ready);
    check_eq("out valid after reset", 0, debug_out_valid);

    // Identity, bad address, read-only write, oversize request
    read_reg(`CTM_REG_MOD_ID);
    expect_resp("read mod id", `CTM_SUB_RESP_READ, 1'b1, `CTM_MOD_TYPE);
    read_reg(`CTM_REG_VERSION);
    expect_resp("read version", `CTM_SUB_RESP_READ, 1'b1, `CTM_MOD_VERSION);
    read_reg(16'd7);
    expect_resp("read addr 7", `CTM_SUB_RESP_ERROR, 1'b0, '0);
    write_reg(`CTM_REG_MOD_ID, 16'h1234);
    expect_resp("write mod id", `CTM_SUB_RESP_ERROR, 1'b0, '0);
    tx_pkt = '{DUT_ID, HOST, {`CTM_TYPE_REG, `CTM_SUB_REQ_READ, 10'b0}, `CTM_REG_VERSION};
    repeat (6) tx_pkt.push_back(16'hdead);   // 10 flits, over the limit
    send_packet();
    expect_quiet(60);

    // Destination register, then disabled trace
    write_reg(`CTM_REG_EVENT_DEST, DEST);
    expect_resp("write event dest", `CTM_SUB_RESP_WRITE, 1'b0, '0);
    read_reg(`CTM_REG_EVENT_DEST);
    expect_resp("read event dest", `CTM_SUB_RESP_READ, 1'b1, DEST);
    issue_instr(1'b1, 1'b0, 32'h0000_4400, 32'h0000_5000);
    issue_instr(1'b0, 1'b1, 32'h0000_5010, 32'h0000_4404);
    trace_idle();
    expect_quiet(40);
    write_reg(`CTM_REG_CTRL, 16'h0001);
    expect_resp("write ctrl", `CTM_SUB_RESP_WRITE, 1'b0, '0);
    trace_on = 1'b1;
    read_reg(`CTM_REG_CTRL);
    expect_resp("read ctrl", `CTM_SUB_RESP_READ, 1'b1, 16'h0001);

    // One packet per jump, none for plain instructions
    for (int i = 0; i < 4; i++) begin
      issue_instr(i % 2 == 0, i % 2 == 1, 32'h0001_2000 + 32'(i * 8), 32'h8000_0100 + 32'(i));
      trace_idle();
      get_packet("event packet");
      check_event();
    end
    issue_instr(1'b0, 1'b0, 32'h0000_6000, 32'h0000_6002);
    trace_idle();
    expect_quiet(40);

    // Random back-pressure
    ready_mode = 1;
    for (int i = 0; i < 12; i++) begin
      issue_instr(i % 3 != 2, i % 3 == 2, 32'h0000_4000 + 32'(i * 6), 32'h0001_0000 ^ 32'(i << 4));
      trace_idle();
      repeat (10 + (i % 4) * 6) @(posedge clk);
    end
    drain_events();

    // Burst into a stalled output, drops carried by a later event
    ready_mode = 2;
    repeat (2) @(posedge clk);
    for (int i = 0; i < 10; i++)
      issue_instr(1'b1, 1'b0, 32'h0002_0000 + 32'(i * 4), 32'h0003_0000 + 32'(i));
    trace_idle();
    repeat (30) @(posedge clk);
    ready_mode = 0;
    wait_out_idle();
    issue_instr(1'b0, 1'b1, 32'h0002_1000, 32'h0002_0004);
    trace_idle();
    drain_events();
    check_eq("events accounted", exp_pc.size(), delivered + drops_total);
    check_eq("drops reported", 1, drops_total > 0);

    // Register read mixed into trace traffic
    ready_mode = 1;
    for (int i = 0; i < 3; i++)
      issue_instr(1'b1, 1'b0, 32'h0004_0000 + 32'(i * 2), 32'h0005_0000 + 32'(i));
    trace_idle();
    read_reg(`CTM_REG_EVENT_DEST);
    expect_resp("read during trace", `CTM_SUB_RESP_READ, 1'b1, DEST);
    drain_events();
    ready_mode = 0;
    expect_quiet(40);

    $display("TEST RESULT: PASS");
    $finish;
  end

endmodule

//--- source/ctm_mmsp430.sv
// Core trace module top level for the MSP430-class CPU trace port
`timescale 1ns/100ps

module ctm_mmsp430 #(
  parameter int MAX_PKT_LEN = 8   // Longest accepted request
) (
  input  logic             clk,
  input  logic             reset,
  input  ctm_pkg::mod_id_t id,
  // CPU execution trace
  input  logic             trace_valid,
  input  ctm_pkg::addr_t   trace_pc,
  input  ctm_pkg::addr_t   trace_jbtarget,  // Used as npc
  input  logic             trace_jal,
  input  logic             trace_jr,
  // Debug input
  input  ctm_pkg::flit_t   debug_in_data,
  input  logic             debug_in_last,
  input  logic             debug_in_valid,
  output logic             debug_in_ready,
  // Debug output
  output ctm_pkg::flit_t   debug_out_data,
  output logic             debug_out_last,
  output logic             debug_out_valid,
  input  logic             debug_out_ready
);

  // Detector to buffer
  logic                  push;
  logic                  full;
  ctm_pkg::tstamp_t      ev_tstamp;
  ctm_pkg::addr_t        ev_pc;
  ctm_pkg::addr_t        ev_npc;
  logic                  ev_call;
  logic                  ev_ret;
  ctm_pkg::drop_cnt_t    ev_drops;

  // Buffer head to mux
  logic                  trace_req;
  logic                  trace_ack;
  ctm_pkg::tstamp_t      head_tstamp;
  ctm_pkg::addr_t        head_pc;
  ctm_pkg::addr_t        head_npc;
  logic                  head_call;
  logic                  head_ret;
  ctm_pkg::drop_cnt_t    head_drops;

  // Register block
  logic                  trace_enable;
  ctm_pkg::mod_id_t      event_dest;
  logic                  resp_req;
  logic                  resp_ack;
  ctm_pkg::mod_id_t      resp_dest;
  ctm_pkg::flit_t        resp_hdr;
  ctm_pkg::flit_t        resp_data;
  logic                  resp_has_data;

  ctm_event_detect u_detect (.*);

  ctm_event_fifo u_fifo (.*);

  ctm_reg_access #(
    .MAX_PKT_LEN(MAX_PKT_LEN)
  ) u_regs (.*);

  ctm_packet_mux u_mux (.*);

endmodule

//--- source/ctm_packet_mux.sv
// Output packet selector and flit sequencer for trace and response packets
`timescale 1ns/100ps
`include "ctm_defs.svh"

module ctm_packet_mux (
  input  logic               clk,
  input  logic               reset,
  input  ctm_pkg::mod_id_t   id,
  input  ctm_pkg::mod_id_t   event_dest,
  input  logic               trace_req,
  output logic               trace_ack,
  input  ctm_pkg::tstamp_t   head_tstamp,
  input  ctm_pkg::addr_t     head_pc,
  input  ctm_pkg::addr_t     head_npc,
  input  logic               head_call,
  input  logic               head_ret,
  input  ctm_pkg::drop_cnt_t head_drops,
  input  logic               resp_req,
  output logic               resp_ack,
  input  ctm_pkg::mod_id_t   resp_dest,
  input  ctm_pkg::flit_t     resp_hdr,
  input  ctm_pkg::flit_t     resp_data,
  input  logic               resp_has_data,
  output ctm_pkg::flit_t     debug_out_data,
  output logic               debug_out_last,
  output logic               debug_out_valid,
  input  logic               debug_out_ready
);

  localparam int IDX_W = $clog2(`CTM_EVENT_FLITS);

  ctm_pkg::tx_state_t state;
  logic [IDX_W-1:0]   idx;        // Flit position in packet
  logic               sel_resp;   // 1: response, 0: trace
  ctm_pkg::mod_id_t   ev_dest_q;  // Destination frozen for the packet
  ctm_pkg::flit_t     ev_flit;
  ctm_pkg::flit_t     rsp_flit;
  logic               ev_last;
  logic               rsp_last;
  logic               src_req;

  assign src_req         = sel_resp ? resp_req : trace_req;
  assign debug_out_valid = (state == ctm_pkg::TX_FLITS);
  assign debug_out_data  = sel_resp ? rsp_flit : ev_flit;
  assign debug_out_last  = sel_resp ? rsp_last : ev_last;

  assign ev_last  = (idx == IDX_W'(`CTM_EVENT_FLITS - 1));
  assign rsp_last = (idx == (resp_has_data ? IDX_W'(3) : IDX_W'(2)));

  // Flit word by position
  always_comb begin
    case (idx)
      IDX_W'(0): ev_flit = ev_dest_q;
      IDX_W'(1): ev_flit = id;
      IDX_W'(2): ev_flit = {`CTM_TYPE_EVENT, 14'b0};
      IDX_W'(3): ev_flit = head_tstamp[15:0];
      IDX_W'(4): ev_flit = head_tstamp[31:16];
      IDX_W'(5): ev_flit = head_pc[15:0];
      IDX_W'(6): ev_flit = head_pc[31:16];
      IDX_W'(7): ev_flit = head_npc[15:0];
      IDX_W'(8): ev_flit = head_npc[31:16];
      default:   ev_flit = {head_drops, 6'b0, head_ret, head_call};  // Flags
    endcase
    case (idx)
      IDX_W'(0): rsp_flit = resp_dest;
      IDX_W'(1): rsp_flit = id;
      IDX_W'(2): rsp_flit = resp_hdr;
      default:   rsp_flit = resp_data;
    endcase
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      state     <= ctm_pkg::TX_IDLE;
      idx       <= '0;
      sel_resp  <= 1'b0;
      trace_ack <= 1'b0;
      resp_ack  <= 1'b0;
    end else begin
      case (state)
        ctm_pkg::TX_IDLE: begin
          idx <= '0;
          if (resp_req || trace_req) begin
            sel_resp <= resp_req;        // Response wins at a boundary
            state    <= ctm_pkg::TX_FLITS;
          end
        end
        ctm_pkg::TX_FLITS: begin
          if (debug_out_ready) begin     // Otherwise just hold
            if (debug_out_last) begin
              trace_ack <= !sel_resp;
              resp_ack  <= sel_resp;
              state     <= ctm_pkg::TX_ACK_WAIT;
            end else begin
              idx <= idx + 1'b1;
            end
          end
        end
        ctm_pkg::TX_ACK_WAIT: begin
          if (!src_req) begin            // Source released, step 4
            trace_ack <= 1'b0;
            resp_ack  <= 1'b0;
            state     <= ctm_pkg::TX_RELEASE;
          end
        end
        default: state <= ctm_pkg::TX_IDLE;   // Ack low one cycle
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (state == ctm_pkg::TX_IDLE)
      ev_dest_q <= event_dest;
  end

  // Held flit must not change under back-pressure
  a_flit_hold: assert property (@(posedge clk) disable iff (reset)
    debug_out_valid && !debug_out_ready |=>
      debug_out_valid && $stable(debug_out_data) && $stable(debug_out_last));

endmodule

//--- source/ctm_reg_access.sv
// Register request parser, register file and response builder
`timescale 1ns/100ps
`include "ctm_defs.svh"

module ctm_reg_access #(
  parameter int MAX_PKT_LEN = 8
) (
  input  logic             clk,
  input  logic             reset,
  input  ctm_pkg::mod_id_t id,
  input  ctm_pkg::flit_t   debug_in_data,
  input  logic             debug_in_last,
  input  logic             debug_in_valid,
  output logic             debug_in_ready,
  input  logic             resp_ack,
  output logic             trace_enable,
  output ctm_pkg::mod_id_t event_dest,
  output logic             resp_req,
  output ctm_pkg::mod_id_t resp_dest,
  output ctm_pkg::flit_t   resp_hdr,
  output ctm_pkg::flit_t   resp_data,
  output logic             resp_has_data
);

  localparam int CNT_W = $clog2(MAX_PKT_LEN + 2);

  ctm_pkg::rx_state_t state;
  logic [CNT_W-1:0]   cnt;        // Flits taken so far in this packet
  logic [3:0]         req_sub;
  ctm_pkg::flit_t     req_addr;
  ctm_pkg::flit_t     cur_addr;
  ctm_pkg::flit_t     rd_val;
  logic               take;
  logic               too_long;
  logic               done;       // Last flit of a well-formed request
  logic               is_read;
  logic               reg_hit;
  logic               wr_ok;
  logic [3:0]         resp_sub;

  assign debug_in_ready = !resp_req;   // Stall input while answering
  assign take     = debug_in_valid && debug_in_ready;
  assign too_long = (cnt >= CNT_W'(MAX_PKT_LEN));
  assign is_read  = (state == ctm_pkg::RX_ADDR);  // Reads end on address flit
  assign done     = take && debug_in_last && !too_long &&
                    ((is_read && req_sub == `CTM_SUB_REQ_READ) ||
                     state == ctm_pkg::RX_DATA);
  assign cur_addr = is_read ? debug_in_data : req_addr;

  // Register decode
  always_comb begin
    reg_hit = 1'b1;
    wr_ok   = 1'b0;
    rd_val  = '0;
    case (cur_addr)
      `CTM_REG_MOD_ID:  rd_val = `CTM_MOD_TYPE;
      `CTM_REG_VERSION: rd_val = `CTM_MOD_VERSION;
      `CTM_REG_EVENT_DEST: begin
        rd_val = event_dest;
        wr_ok  = 1'b1;
      end
      `CTM_REG_CTRL: begin
        rd_val = {15'b0, trace_enable};
        wr_ok  = 1'b1;
      end
      default: reg_hit = 1'b0;   // Unknown address
    endcase
    if (!reg_hit || (!is_read && !wr_ok))
      resp_sub = `CTM_SUB_RESP_ERROR;
    else
      resp_sub = is_read ? `CTM_SUB_RESP_READ : `CTM_SUB_RESP_WRITE;
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      state        <= ctm_pkg::RX_DEST;
      cnt          <= '0;
      resp_req     <= 1'b0;
      trace_enable <= 1'b0;
      event_dest   <= '0;
    end else begin
      if (resp_req && resp_ack)
        resp_req <= 1'b0;          // Mux is done, back to receiving
      if (done) begin
        resp_req <= 1'b1;
        if (!is_read && wr_ok && req_addr == `CTM_REG_EVENT_DEST)
          event_dest <= debug_in_data;
        if (!is_read && wr_ok && req_addr == `CTM_REG_CTRL)
          trace_enable <= debug_in_data[0];
      end
      if (take) begin
        cnt <= too_long ? cnt : cnt + 1'b1;
        case (state)
          ctm_pkg::RX_DEST: state <= (debug_in_data == id) ? ctm_pkg::RX_SRC
                                                            : ctm_pkg::RX_DRAIN;
          ctm_pkg::RX_SRC:  state <= ctm_pkg::RX_HDR;
          ctm_pkg::RX_HDR: begin
            if (debug_in_data[`CTM_HDR_TYPE] == `CTM_TYPE_REG &&
                (debug_in_data[`CTM_HDR_SUB] == `CTM_SUB_REQ_READ ||
                 debug_in_data[`CTM_HDR_SUB] == `CTM_SUB_REQ_WRITE))
              state <= ctm_pkg::RX_ADDR;
            else
              state <= ctm_pkg::RX_DRAIN;   // Not a register request
          end
          ctm_pkg::RX_ADDR: state <= (req_sub == `CTM_SUB_REQ_WRITE) ? ctm_pkg::RX_DATA
                                                                      : ctm_pkg::RX_DRAIN;
          default: state <= ctm_pkg::RX_DRAIN;  // Extra flits after data
        endcase
        if (too_long)
          state <= ctm_pkg::RX_DRAIN;
        if (debug_in_last) begin
          state <= ctm_pkg::RX_DEST;     // Short packets drop here too
          cnt   <= '0;
        end
      end
    end
  end

  // Request fields and response words
  always_ff @(posedge clk) begin
    if (take && state == ctm_pkg::RX_SRC)
      resp_dest <= debug_in_data;     // Answer goes back to sender
    if (take && state == ctm_pkg::RX_HDR)
      req_sub <= debug_in_data[`CTM_HDR_SUB];
    if (take && state == ctm_pkg::RX_ADDR)
      req_addr <= debug_in_data;
    if (done) begin
      resp_hdr      <= {`CTM_TYPE_REG, resp_sub, 10'b0};
      resp_data     <= rd_val;
      resp_has_data <= (resp_sub == `CTM_SUB_RESP_READ);
    end
  end

endmodule

//--- source/ctm_event_fifo.sv
// Circular event buffer offering its head entry by four-phase handshake
`timescale 1ns/100ps
`include "ctm_defs.svh"

module ctm_event_fifo (
  input  logic               clk,
  input  logic               reset,
  input  logic               push,
  input  ctm_pkg::tstamp_t   ev_tstamp,
  input  ctm_pkg::addr_t     ev_pc,
  input  ctm_pkg::addr_t     ev_npc,
  input  logic               ev_call,
  input  logic               ev_ret,
  input  ctm_pkg::drop_cnt_t ev_drops,
  input  logic               trace_ack,
  output logic               full,
  output logic               trace_req,
  output ctm_pkg::tstamp_t   head_tstamp,
  output ctm_pkg::addr_t     head_pc,
  output ctm_pkg::addr_t     head_npc,
  output logic               head_call,
  output logic               head_ret,
  output ctm_pkg::drop_cnt_t head_drops
);

  localparam int DEPTH = `CTM_FIFO_DEPTH;
  localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CNT_W = $clog2(DEPTH + 1);

  ctm_pkg::tstamp_t   mem_tstamp [DEPTH];
  ctm_pkg::addr_t     mem_pc     [DEPTH];
  ctm_pkg::addr_t     mem_npc    [DEPTH];
  logic [1:0]         mem_flags  [DEPTH];   // {ret, call}
  ctm_pkg::drop_cnt_t mem_drops  [DEPTH];

  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [CNT_W-1:0] count;
  logic             pop;

  function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] p);
    return (p == PTR_W'(DEPTH - 1)) ? '0 : p + 1'b1;   // Any depth wraps
  endfunction

  assign pop  = trace_req && trace_ack;    // Step 3 of handshake
  // Counts the push in flight, detector samples full an edge early
  assign full = (count == CNT_W'(DEPTH)) || (push && count == CNT_W'(DEPTH - 1));

  always_ff @(posedge clk) begin
    if (reset) begin
      wr_ptr    <= '0;
      rd_ptr    <= '0;
      count     <= '0;
      trace_req <= 1'b0;
    end else begin
      if (push)
        wr_ptr <= ptr_inc(wr_ptr);
      if (pop)
        rd_ptr <= ptr_inc(rd_ptr);
      count <= count + CNT_W'(push) - CNT_W'(pop);
      if (pop)
        trace_req <= 1'b0;
      else if (!trace_req && !trace_ack && count != '0)
        trace_req <= 1'b1;   // Offer head once mux has released ack
    end
  end

  always_ff @(posedge clk) begin
    if (push) begin
      mem_tstamp[wr_ptr] <= ev_tstamp;
      mem_pc[wr_ptr]     <= ev_pc;
      mem_npc[wr_ptr]    <= ev_npc;
      mem_flags[wr_ptr]  <= {ev_ret, ev_call};
      mem_drops[wr_ptr]  <= ev_drops;
    end
  end

  // Head stays put while req is high
  assign head_tstamp = mem_tstamp[rd_ptr];
  assign head_pc     = mem_pc[rd_ptr];
  assign head_npc    = mem_npc[rd_ptr];
  assign head_call   = mem_flags[rd_ptr][0];
  assign head_ret    = mem_flags[rd_ptr][1];
  assign head_drops  = mem_drops[rd_ptr];

  // Push never lands on a full buffer
  a_no_overflow: assert property (@(posedge clk) disable iff (reset)
    push |-> count != CNT_W'(DEPTH));

  // Mux acknowledges only an offered head
  a_ack_after_req: assert property (@(posedge clk) disable iff (reset)
    $rose(trace_ack) |-> trace_req);

endmodule

//--- source/ctm_event_detect.sv
// Call and return detection with timestamp and drop counters
`timescale 1ns/100ps

module ctm_event_detect (
  input  logic               clk,
  input  logic               reset,
  input  logic               trace_valid,
  input  ctm_pkg::addr_t     trace_pc,
  input  ctm_pkg::addr_t     trace_jbtarget,
  input  logic               trace_jal,
  input  logic               trace_jr,
  input  logic               trace_enable,
  input  logic               full,
  output logic               push,
  output ctm_pkg::tstamp_t   ev_tstamp,
  output ctm_pkg::addr_t     ev_pc,
  output ctm_pkg::addr_t     ev_npc,
  output logic               ev_call,
  output logic               ev_ret,
  output ctm_pkg::drop_cnt_t ev_drops
);

  ctm_pkg::tstamp_t   tstamp;   // Free-running cycle count
  ctm_pkg::drop_cnt_t drops;    // Events lost since last push
  logic               ev_hit;
  logic               accept;

  assign ev_hit = trace_valid && trace_enable && (trace_jal || trace_jr);
  assign accept = ev_hit && !full;

  always_ff @(posedge clk) begin
    if (reset) begin
      tstamp <= '0;
      drops  <= '0;
      push   <= 1'b0;
    end else begin
      tstamp <= tstamp + 1'b1;
      push   <= accept;                // Lands in buffer next edge
      if (ev_hit && full) begin
        if (drops != '1)
          drops <= drops + 1'b1;       // Saturate
      end else if (accept) begin
        drops <= '0;                   // Handed over with this event
      end
    end
  end

  // Event words, only sampled on accept
  always_ff @(posedge clk) begin
    if (accept) begin
      ev_tstamp <= tstamp;             // Count at the accepting edge
      ev_pc     <= trace_pc;
      ev_npc    <= trace_jbtarget;
      ev_call   <= trace_jal;
      ev_ret    <= trace_jr;
      ev_drops  <= drops;
    end
  end

endmodule

//--- source/ctm_pkg.sv
// Shared vector types and FSM state encodings of the core trace module
`include "ctm_defs.svh"

package ctm_pkg;

  typedef logic [`CTM_FLIT_W-1:0]   flit_t;     // One debug flit payload
  typedef logic [`CTM_ADDR_W-1:0]   addr_t;     // Program counter
  typedef logic [`CTM_TSTAMP_W-1:0] tstamp_t;   // Cycle count
  typedef logic [`CTM_DROP_W-1:0]   drop_cnt_t; // Saturating drop count
  typedef logic [`CTM_MOD_ID_W-1:0] mod_id_t;   // Debug network address

  // Request parser, one state per flit position
  typedef enum logic [2:0] {
    RX_DEST,
    RX_SRC,
    RX_HDR,
    RX_ADDR,
    RX_DATA,
    RX_DRAIN   // Discard rest of packet
  } rx_state_t;

  // Output sequencer
  typedef enum logic [1:0] {
    TX_IDLE,
    TX_ACK_WAIT,  // Ack high until source drops req
    TX_FLITS,
    TX_RELEASE
  } tx_state_t;

endpackage

//--- source/ctm_defs.svh
// Width, depth, register address and packet code macros for the core trace module
`ifndef CTM_DEFS_SVH
`define CTM_DEFS_SVH

// Vector widths
`define CTM_FLIT_W        16
`define CTM_ADDR_W        32
`define CTM_TSTAMP_W      32
`define CTM_DROP_W        8
`define CTM_MOD_ID_W      16

`define CTM_FIFO_DEPTH    4        // Event buffer entries
`define CTM_EVENT_FLITS   10       // dest, src, hdr, 2x tstamp, 2x pc, 2x npc, flags

// Identity
`define CTM_MOD_TYPE      16'h0005
`define CTM_MOD_VERSION   16'h0001

// Register map
`define CTM_REG_MOD_ID    16'd0
`define CTM_REG_VERSION   16'd1
`define CTM_REG_EVENT_DEST 16'd2
`define CTM_REG_CTRL      16'd3

// Header flit fields
`define CTM_HDR_TYPE      15:14
`define CTM_HDR_SUB       13:10
`define CTM_TYPE_REG      2'd0
`define CTM_TYPE_EVENT    2'd2

// Subtypes
`define CTM_SUB_REQ_READ    4'd0
`define CTM_SUB_REQ_WRITE   4'd1
`define CTM_SUB_RESP_READ   4'd8
`define CTM_SUB_RESP_WRITE  4'd9
`define CTM_SUB_RESP_ERROR  4'd10

`endif
